// File: rtl/nn_cfg.svh
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// network dimensions
`define NEURON_NUM          5   // widest layer, also the number of parallel neurons
`define LAYER_MAX           3   // layer numbers 0 .. LAYER_MAX-1 are valid
`define LAYER_ADDR_WIDTH    2   // bits of the layer number

// number format
`define ACTIVATION_WIDTH    9   // unsigned activation
`define WEIGHT_CELL_WIDTH   16  // signed weight, fraction bits included
`define FRACTION            0   // fraction bits of a weight

// neuron sum after saturation, signed
`define NEURON_OUTPUT_WIDTH 10

// internal accumulator, roomy enough for NEURON_NUM full-scale products
`define ACC_WIDTH           32

`endif

// File: rtl/nn_pkg.sv
`include "nn_cfg.svh"

package nn_pkg;

    // counts 0 .. NEURON_NUM, one extra bit so NEURON_NUM itself fits
    typedef logic [$clog2(`NEURON_NUM):0] neuron_count_t;

    typedef logic [`ACTIVATION_WIDTH-1:0]           activation_t;  // unsigned
    typedef logic signed [`WEIGHT_CELL_WIDTH-1:0]   weight_t;      // two's complement
    typedef logic signed [`NEURON_OUTPUT_WIDTH-1:0] neuron_sum_t;  // saturated sum
    typedef logic [`LAYER_ADDR_WIDTH-1:0]           layer_num_t;

    // element i is input i of every neuron
    typedef activation_t [`NEURON_NUM-1:0] activation_vec_t;

    // element i of a row multiplies input i
    typedef weight_t [`NEURON_NUM-1:0] weight_row_t;

    // row j feeds neuron j of the current layer
    typedef weight_row_t [`NEURON_NUM-1:0] weight_mat_t;

    typedef neuron_sum_t [`NEURON_NUM-1:0] sum_vec_t;

    // one layer command from the host
    typedef struct packed {
        layer_num_t    layer_number;  // 0 selects the start activations
        neuron_count_t curr_neurons;  // neurons producing a sum
        neuron_count_t prev_neurons;  // terms per neuron
    } layer_cmd_t;

    // what comes back for one layer
    typedef struct packed {
        sum_vec_t sums;
        logic     overflow;  // any active neuron clipped
    } layer_result_t;

    // controller of forward
    typedef enum logic [1:0] {
        IDLE,  // accepting inputs, weights and commands
        RUN,   // layer in progress
        HOLD   // result waiting for the host
    } fwd_state_e;

endpackage

// File: rtl/neuron.sv
`timescale 1ns/1ps

`include "nn_cfg.svh"

module neuron (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  nn_pkg::neuron_count_t   prev_neurons,
    input  nn_pkg::activation_vec_t inputs,
    input  nn_pkg::weight_row_t     weight_row,
    output logic                    done,
    output nn_pkg::neuron_sum_t     sum,
    output logic                    overflow
);
    import nn_pkg::*;

    // signed range of a neuron sum, in accumulator width
    localparam logic signed [`ACC_WIDTH-1:0] SUM_MAX = 2 ** (`NEURON_OUTPUT_WIDTH - 1) - 1;
    localparam logic signed [`ACC_WIDTH-1:0] SUM_MIN = -(2 ** (`NEURON_OUTPUT_WIDTH - 1));

    neuron_count_t                  idx;      // next term to add
    logic                           busy;
    logic                           last;     // all prev_neurons terms are in
    logic signed [`ACC_WIDTH-1:0]   acc;
    logic signed [`ACC_WIDTH-1:0]   act_ext;
    logic signed [`ACC_WIDTH-1:0]   wt_ext;
    logic signed [`ACC_WIDTH-1:0]   product;
    logic signed [`ACC_WIDTH-1:0]   shifted;
    logic                           clip_hi;
    logic                           clip_lo;
    neuron_sum_t                    sat_sum;

    // one product per cycle, index guarded against counts above NEURON_NUM
    always_comb begin
        act_ext = '0;
        wt_ext  = '0;
        if (idx < `NEURON_NUM) begin
            act_ext = `ACC_WIDTH'(inputs[idx]);                // zero extended
            wt_ext  = `ACC_WIDTH'($signed(weight_row[idx]));   // sign extended
        end
        product = act_ext * wt_ext;
    end

    assign last = (idx == prev_neurons);

    // drop the fraction, then clip to the output range
    assign shifted = acc >>> `FRACTION;
    assign clip_hi = (shifted > SUM_MAX);
    assign clip_lo = (shifted < SUM_MIN);

    always_comb begin
        if (clip_hi) begin
            sat_sum = neuron_sum_t'(SUM_MAX);
        end else if (clip_lo) begin
            sat_sum = neuron_sum_t'(SUM_MIN);
        end else begin
            sat_sum = shifted[`NEURON_OUTPUT_WIDTH-1:0];
        end
    end

    // sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // single cycle pulse
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy && !last) begin
            acc <= acc + product;
        end
        if (busy && last) begin
            sum      <= sat_sum;
            overflow <= clip_hi | clip_lo;
        end
    end

endmodule

// File: rtl/layer.sv
`timescale 1ns/1ps

`include "nn_cfg.svh"

module layer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  nn_pkg::layer_cmd_t      cmd,
    input  nn_pkg::activation_vec_t inputs,
    input  nn_pkg::weight_mat_t     weights,
    output logic                    done,
    output nn_pkg::layer_result_t   result
);
    import nn_pkg::*;

    logic [`NEURON_NUM-1:0] n_done;
    logic [`NEURON_NUM-1:0] n_ovf;
    logic [`NEURON_NUM-1:0] active;      // neuron index below curr_neurons
    logic                   all_done;
    sum_vec_t               n_sum;
    sum_vec_t               masked_sum;

    genvar j;
    generate
        for (j = 0; j < `NEURON_NUM; j = j + 1) begin : g_neuron
            neuron i_neuron (
                .clk          (clk),
                .rst          (rst),
                .start        (start),
                .prev_neurons (cmd.prev_neurons),
                .inputs       (inputs),
                .weight_row   (weights[j]),
                .done         (n_done[j]),
                .sum          (n_sum[j]),
                .overflow     (n_ovf[j])
            );

            assign active[j]     = (j < cmd.curr_neurons);
            assign masked_sum[j] = active[j] ? n_sum[j] : '0;  // unused neurons read zero
        end
    endgenerate

    // every neuron runs the same count, so they finish together
    assign all_done = &n_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= all_done;
        end
    end

    // result register, loaded once per layer
    always_ff @(posedge clk) begin
        if (all_done) begin
            result.sums     <= masked_sum;
            result.overflow <= |(n_ovf & active);  // only active neurons count
        end
    end

endmodule

// File: rtl/forward.sv
`timescale 1ns/1ps

`include "nn_cfg.svh"

module forward (
    input  logic                    clk,
    input  logic                    rst,

    // start activations for layer 0
    input  nn_pkg::activation_vec_t start_inputs,
    input  logic                    start_inputs_valid,
    output logic                    start_inputs_ready,

    // weight matrix, one per layer command
    input  nn_pkg::weight_mat_t     weights,
    input  logic                    weights_valid,
    output logic                    weights_ready,

    // layer command
    input  nn_pkg::layer_cmd_t      layer_cmd,
    input  logic                    layer_cmd_valid,
    output logic                    layer_cmd_ready,

    // layer result towards the host
    output nn_pkg::layer_result_t   result,
    output logic                    result_valid,
    input  logic                    result_ready
);
    import nn_pkg::*;

    fwd_state_e      state;
    logic            weights_held;   // a matrix waits for its command
    weight_mat_t     weight_q;
    layer_cmd_t      cmd_q;          // command of the layer in flight
    activation_vec_t start_q;        // latest start activations
    activation_vec_t feedback_q;     // relu of the last result
    activation_vec_t layer_inputs;
    activation_vec_t relu_vec;
    layer_result_t   result_q;
    layer_result_t   layer_result;
    logic            layer_start;
    logic            layer_done;
    logic            start_fire;
    logic            weights_fire;
    logic            cmd_fire;

    // handshakes
    assign start_inputs_ready = (state == IDLE);
    assign weights_ready      = (state == IDLE) && !weights_held;
    // a command needs a matrix, held or arriving this cycle
    assign layer_cmd_ready    = (state == IDLE) && (weights_held || weights_valid);

    assign start_fire   = start_inputs_valid && start_inputs_ready;
    assign weights_fire = weights_valid && weights_ready;
    assign cmd_fire     = layer_cmd_valid && layer_cmd_ready;

    // controller
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_fire) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (layer_done) begin
                        state <= HOLD;   // result captured on this edge
                    end
                end
                HOLD: begin
                    if (result_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // start pulse one cycle after the command is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            layer_start <= 1'b0;
        end else begin
            layer_start <= cmd_fire;
        end
    end

    // weight holding, the command consumes the matrix
    always_ff @(posedge clk) begin
        if (rst) begin
            weights_held <= 1'b0;
        end else if (cmd_fire) begin
            weights_held <= 1'b0;
        end else if (weights_fire) begin
            weights_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (weights_fire) begin
            weight_q <= weights;
        end
        if (cmd_fire) begin
            cmd_q <= layer_cmd;
        end
    end

    // activation registers
    always_ff @(posedge clk) begin
        if (rst) begin
            start_q    <= '0;
            feedback_q <= '0;
        end else begin
            if (start_fire) begin
                start_q <= start_inputs;   // seen by a command in the same cycle
            end
            if (state == RUN && layer_done) begin
                feedback_q <= relu_vec;
            end
        end
    end

    // relu on the fresh result, low bits of a non-negative sum always fit
    always_comb begin
        for (int i = 0; i < `NEURON_NUM; i++) begin
            if (layer_result.sums[i][`NEURON_OUTPUT_WIDTH-1]) begin
                relu_vec[i] = '0;
            end else begin
                relu_vec[i] = layer_result.sums[i][`ACTIVATION_WIDTH-1:0];
            end
        end
    end

    // layer 0 starts from the host vector, the rest chain on the feedback
    assign layer_inputs = (cmd_q.layer_number == '0) ? start_q : feedback_q;

    layer i_layer (
        .clk     (clk),
        .rst     (rst),
        .start   (layer_start),
        .cmd     (cmd_q),
        .inputs  (layer_inputs),
        .weights (weight_q),
        .done    (layer_done),
        .result  (layer_result)
    );

    // result holds under back-pressure
    always_ff @(posedge clk) begin
        if (state == RUN && layer_done) begin
            result_q <= layer_result;
        end
    end

    assign result       = result_q;
    assign result_valid = (state == HOLD);

endmodule

// File: testbench/forward_checker.sv
`timescale 1ns/1ps

`include "nn_cfg.svh"

module forward_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  start_inputs_ready,
    input logic                  weights_ready,
    input nn_pkg::layer_cmd_t    layer_cmd,
    input logic                  layer_cmd_valid,
    input logic                  layer_cmd_ready,
    input nn_pkg::layer_result_t result,
    input logic                  result_valid,
    input logic                  result_ready
);
    int   fail_count = 0;   // failed assertions so far
    logic in_flight;        // command taken, result not yet handed over

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (layer_cmd_valid && layer_cmd_ready) begin
            in_flight <= 1'b1;
        end else if (result_valid && result_ready) begin
            in_flight <= 1'b0;
        end
    end

    // a stalled result keeps valid and data
    a_result_held: assert property (@(posedge clk) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)))
    else begin
        fail_count++;
        $error("result changed or dropped while stalled");
    end

    // one layer in flight
    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !(start_inputs_ready || weights_ready || layer_cmd_ready))
    else begin
        fail_count++;
        $error("input ready high while a layer is in flight");
    end

    a_cmd_range: assert property (@(posedge clk) disable iff (rst)
        (layer_cmd_valid && layer_cmd_ready) |-> (layer_cmd.layer_number < `LAYER_MAX))
    else begin
        fail_count++;
        $error("accepted command with layer number out of range");
    end

endmodule

bind forward forward_checker i_forward_checker (
    .clk                (clk),
    .rst                (rst),
    .start_inputs_ready (start_inputs_ready),
    .weights_ready      (weights_ready),
    .layer_cmd          (layer_cmd),
    .layer_cmd_valid    (layer_cmd_valid),
    .layer_cmd_ready    (layer_cmd_ready),
    .result             (result),
    .result_valid       (result_valid),
    .result_ready       (result_ready)
);

// File: testbench/tb_forward.sv
`timescale 1ns/1ps

`include "nn_cfg.svh"

module tb_forward;
    import nn_pkg::*;

    localparam int TIMEOUT = 100;   // cycles allowed for any single wait
    localparam int SUM_MAX = 2 ** (`NEURON_OUTPUT_WIDTH - 1) - 1;
    localparam int SUM_MIN = -(2 ** (`NEURON_OUTPUT_WIDTH - 1));

    logic            clk;
    logic            rst;
    activation_vec_t start_inputs;
    logic            start_inputs_valid;
    logic            start_inputs_ready;
    weight_mat_t     weights;
    logic            weights_valid;
    logic            weights_ready;
    layer_cmd_t      layer_cmd;
    logic            layer_cmd_valid;
    logic            layer_cmd_ready;
    layer_result_t   result;
    logic            result_valid;
    logic            result_ready;

    integer          seed;
    int              errors;
    int              checks;
    logic            timed_out;
    activation_vec_t start_m;      // model copy of the start activations
    activation_vec_t feedback_m;   // model copy of the relu feedback

    forward i_forward (.*);

    always #10 clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic activation_vec_t rand_vec();
        activation_vec_t v;
        for (int i = 0; i < `NEURON_NUM; i++) begin
            v[i] = activation_t'(rand_range(0, 120));
        end
        return v;
    endfunction

    // accumulate, shift, saturate and mask, per the number format
    function automatic layer_result_t model_layer(input layer_cmd_t cmd, input weight_mat_t w,
                                                  input activation_vec_t in_v);
        layer_result_t r;
        longint        acc;
        longint        act;
        weight_t       wt;
        r = '0;
        for (int j = 0; j < cmd.curr_neurons && j < `NEURON_NUM; j++) begin
            acc = 0;
            for (int i = 0; i < cmd.prev_neurons && i < `NEURON_NUM; i++) begin
                act = in_v[i];   // unsigned, zero extended
                wt  = w[j][i];
                acc = acc + act * longint'(wt);
            end
            acc = acc >>> `FRACTION;
            if (acc > SUM_MAX) begin
                acc        = SUM_MAX;
                r.overflow = 1'b1;
            end else if (acc < SUM_MIN) begin
                acc        = SUM_MIN;
                r.overflow = 1'b1;
            end
            r.sums[j] = neuron_sum_t'(acc);
        end
        return r;
    endfunction

    function automatic activation_vec_t relu(input layer_result_t r);
        activation_vec_t v;
        neuron_sum_t     s;
        for (int i = 0; i < `NEURON_NUM; i++) begin
            s    = r.sums[i];
            v[i] = (s < 0) ? '0 : activation_t'(s);   // negative sums give zero
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic send_start(input activation_vec_t v);
        int   waited;
        logic taken;
        if (timed_out) return;
        start_inputs       = v;
        start_inputs_valid = 1'b1;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk);
            taken  = start_inputs_ready;   // value at the edge, before the update
            waited = waited + 1;
            @(negedge clk);
        end
        start_inputs_valid = 1'b0;
        start_m = v;
        if (!taken) note_timeout("start inputs were never accepted");
    endtask

    // one full layer: handshakes, latency, sums, back-pressure, model update
    task automatic run_layer(input layer_cmd_t cmd, input bit big, input bit cmd_first,
                             input int stall);
        weight_mat_t   w;
        layer_result_t exp_r;
        logic          w_done;
        logic          c_done;
        int            waited;
        if (timed_out) return;
        for (int j = 0; j < `NEURON_NUM; j++) begin
            for (int i = 0; i < `NEURON_NUM; i++) begin
                if (big) w[j][i] = weight_t'(rand_range(-4000, 4000));
                else w[j][i] = weight_t'(rand_range(-1, 1));
            end
        end
        exp_r     = model_layer(cmd, w, (cmd.layer_number == 0) ? start_m : feedback_m);
        layer_cmd = cmd;
        weights   = w;
        w_done    = 1'b0;
        c_done    = 1'b0;
        if (cmd_first) begin
            layer_cmd_valid = 1'b1;
            repeat (rand_range(1, 3)) begin   // command parked, no matrix yet
                @(posedge clk);
                checks++;
                if (layer_cmd_ready) begin
                    $display("layer command was accepted without a weight matrix");
                    errors++;
                end
                @(negedge clk);
            end
        end
        weights_valid = 1'b1;
        waited = 0;
        while (!(w_done && c_done) && waited < TIMEOUT) begin
            @(posedge clk);
            if (weights_valid && weights_ready) w_done = 1'b1;
            if (layer_cmd_valid && layer_cmd_ready) c_done = 1'b1;
            waited = waited + 1;
            @(negedge clk);
            if (w_done) weights_valid = 1'b0;
            if (c_done) layer_cmd_valid = 1'b0;
            else if (w_done) layer_cmd_valid = 1'b1;
        end
        if (!(w_done && c_done)) begin
            note_timeout("weights or layer command were never accepted");
            return;
        end
        waited = 0;   // counts edges since the command edge
        while (!result_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!result_valid) begin
            note_timeout("result_valid never rose");
            return;
        end
        check_value("latency", waited, cmd.prev_neurons + 4);
        for (int j = 0; j < `NEURON_NUM; j++) begin
            check_value($sformatf("result.sums[%0d]", j), $unsigned(result.sums[j]),
                        $unsigned(exp_r.sums[j]));
        end
        check_value("result.overflow", result.overflow, exp_r.overflow);
        repeat (stall) begin
            @(negedge clk);
            check_value("result_valid", result_valid, 1'b1);
            check_value("result", result, exp_r);
        end
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        check_value("result_valid", result_valid, 1'b0);   // no second result
        feedback_m = relu(exp_r);
    endtask

    initial begin
        layer_cmd_t cmd;
        int         ref_layers[4];
        bit         big;
        bit         cmd_first;
        int         stall;
        seed               = 32'h7d78bde2;
        errors             = 0;
        checks             = 0;
        timed_out          = 1'b0;
        clk                = 1'b0;
        rst                = 1'b1;
        start_inputs       = '0;
        start_inputs_valid = 1'b0;
        weights            = '0;
        weights_valid      = 1'b0;
        layer_cmd          = '0;
        layer_cmd_valid    = 1'b0;
        result_ready       = 1'b0;
        start_m            = '0;
        feedback_m         = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("start_inputs_ready", start_inputs_ready, 1'b1);
        check_value("weights_ready", weights_ready, 1'b1);
        check_value("result_valid", result_valid, 1'b0);

        // reference order, full width layers
        ref_layers = '{0, 1, 2, 1};
        send_start(rand_vec());
        foreach (ref_layers[k]) begin
            cmd.layer_number = layer_num_t'(ref_layers[k]);
            cmd.curr_neurons = neuron_count_t'(`NEURON_NUM);
            cmd.prev_neurons = neuron_count_t'(`NEURON_NUM);
            run_layer(cmd, 1'b0, 1'b0, 0);
        end

        for (int n = 0; n < 60 && !timed_out; n++) begin
            if (rand_range(0, 3) == 0) send_start(rand_vec());
            cmd.layer_number = layer_num_t'(rand_range(0, `LAYER_MAX - 1));
            cmd.curr_neurons = neuron_count_t'(rand_range(0, `NEURON_NUM));
            cmd.prev_neurons = neuron_count_t'(rand_range(0, `NEURON_NUM));
            big       = (rand_range(0, 4) == 0);    // clipping weights now and then
            cmd_first = (rand_range(0, 2) == 0);
            stall     = rand_range(0, 1) ? rand_range(1, 5) : 0;
            run_layer(cmd, big, cmd_first, stall);
        end

        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_forward.i_forward_checker.fail_count);
        if (errors == 0 && i_forward.i_forward_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
rtl/nn_pkg.sv
rtl/neuron.sv
rtl/layer.sv
rtl/forward.sv
testbench/forward_checker.sv
testbench/tb_forward.sv
